//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

	////////////////////
	// Widths
	////////////////////
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;

	// Instruction field positions
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 26;
	localparam int RS_MSB     = 25;
	localparam int RS_LSB     = 21;
	localparam int RT_MSB     = 20;
	localparam int RT_LSB     = 16;
	localparam int RD_MSB     = 15;
	localparam int RD_LSB     = 11;
	localparam int SHAMT_MSB  = 10;
	localparam int SHAMT_LSB  = 6;
	localparam int FUNCT_MSB  = 5;
	localparam int FUNCT_LSB  = 0;
	localparam int IMM_MSB    = 15;
	localparam int IMM_LSB    = 0;
	localparam int JIDX_MSB   = 25;
	localparam int JIDX_LSB   = 0;

	////////////////////
	// Opcodes and function codes
	////////////////////
	localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'h00;
	localparam logic [OPCODE_W-1:0] OP_J     = 6'h02;
	localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'h04;
	localparam logic [OPCODE_W-1:0] OP_BNE   = 6'h05;
	localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'h08;
	localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'h0c;
	localparam logic [OPCODE_W-1:0] OP_ORI   = 6'h0d;
	localparam logic [OPCODE_W-1:0] OP_LW    = 6'h23;
	localparam logic [OPCODE_W-1:0] OP_SW    = 6'h2b;

	localparam logic [FUNCT_W-1:0] FN_SLL = 6'h00;
	localparam logic [FUNCT_W-1:0] FN_SRL = 6'h02;
	localparam logic [FUNCT_W-1:0] FN_JR  = 6'h08;
	localparam logic [FUNCT_W-1:0] FN_ADD = 6'h20;
	localparam logic [FUNCT_W-1:0] FN_SUB = 6'h22;
	localparam logic [FUNCT_W-1:0] FN_AND = 6'h24;
	localparam logic [FUNCT_W-1:0] FN_OR  = 6'h25;
	localparam logic [FUNCT_W-1:0] FN_SLT = 6'h2a;

	typedef enum logic [3:0] {
		ALU_NOP = 4'd0,
		ALU_ADD = 4'd1,
		ALU_SUB = 4'd2,
		ALU_AND = 4'd3,
		ALU_OR  = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7
	} alu_op_t;

	////////////////////
	// Control words
	////////////////////
	// Execute word, high bit first
	localparam int EXEC_W       = 11;
	localparam int EX_REG_DST   = 10;
	localparam int EX_ALU_SRC   = 9;
	localparam int EX_ALU_OP_HI = 8;
	localparam int EX_ALU_OP_LO = 5;
	localparam int EX_SHIFT_SRC = 4;
	localparam int EX_JUMP      = 3;
	localparam int EX_JUMP_REG  = 2;
	localparam int EX_BRANCH_EQ = 1;
	localparam int EX_BRANCH_NE = 0;

	localparam int MEM_W     = 2;
	localparam int MEM_READ  = 1;
	localparam int MEM_WRITE = 0;

	localparam int WB_W          = 2;
	localparam int WB_REG_WRITE  = 1;
	localparam int WB_MEM_TO_REG = 0;

endpackage

`default_nettype wire

//--- hw/main_control.sv
`default_nettype none

module main_control (
	input  logic [mips_pkg::OPCODE_W-1:0] opcode,
	input  logic [mips_pkg::FUNCT_W-1:0]  funct,
	output logic [mips_pkg::EXEC_W-1:0]   exec_ctrl,
	output logic [mips_pkg::MEM_W-1:0]    mem_ctrl,
	output logic [mips_pkg::WB_W-1:0]     wb_ctrl
);

	import mips_pkg::*;

	always_comb
	begin
		// Anything not listed below leaves all three words at zero
		exec_ctrl = '0;
		mem_ctrl  = '0;
		wb_ctrl   = '0;

		case (opcode)
			OP_RTYPE:
			begin
				case (funct)
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT:
					begin
						exec_ctrl[EX_REG_DST]   = 1'b1;
						wb_ctrl[WB_REG_WRITE]   = 1'b1;
						case (funct)
							FN_ADD:  exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_ADD;
							FN_SUB:  exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_SUB;
							FN_AND:  exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_AND;
							FN_OR:   exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_OR;
							default: exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_SLT;
						endcase
					end
					// Shifts take shamt instead of rs as the first operand
					FN_SLL, FN_SRL:
					begin
						exec_ctrl[EX_REG_DST]   = 1'b1;
						exec_ctrl[EX_SHIFT_SRC] = 1'b1;
						wb_ctrl[WB_REG_WRITE]   = 1'b1;
						if (funct == FN_SLL)
							exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_SLL;
						else
							exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_SRL;
					end
					FN_JR:
						exec_ctrl[EX_JUMP_REG] = 1'b1;
					default:
						exec_ctrl = '0;
				endcase
			end

			////////////////////
			// Immediate forms
			////////////////////
			OP_ADDI, OP_ANDI, OP_ORI:
			begin
				exec_ctrl[EX_ALU_SRC] = 1'b1;
				wb_ctrl[WB_REG_WRITE] = 1'b1;
				if (opcode == OP_ADDI)
					exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_ADD;
				else if (opcode == OP_ANDI)
					exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_AND;
				else
					exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_OR;
			end

			// Loads and stores compute base plus offset
			OP_LW:
			begin
				exec_ctrl[EX_ALU_SRC]                = 1'b1;
				exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_ADD;
				mem_ctrl[MEM_READ]                   = 1'b1;
				wb_ctrl[WB_REG_WRITE]                = 1'b1;
				wb_ctrl[WB_MEM_TO_REG]               = 1'b1;
			end
			OP_SW:
			begin
				exec_ctrl[EX_ALU_SRC]                = 1'b1;
				exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_ADD;
				mem_ctrl[MEM_WRITE]                  = 1'b1;
			end

			// Branches compare by subtraction in execute
			OP_BEQ:
			begin
				exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_SUB;
				exec_ctrl[EX_BRANCH_EQ]              = 1'b1;
			end
			OP_BNE:
			begin
				exec_ctrl[EX_ALU_OP_HI:EX_ALU_OP_LO] = ALU_SUB;
				exec_ctrl[EX_BRANCH_NE]              = 1'b1;
			end
			OP_J:
				exec_ctrl[EX_JUMP] = 1'b1;
			default:
				exec_ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`default_nettype none

module register_file (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr,
	input  logic                            reg_write,
	input  logic [mips_pkg::REG_ADDR_W-1:0] write_register,
	input  logic [mips_pkg::DATA_W-1:0]     write_data,
	output logic [mips_pkg::DATA_W-1:0]     rs_data,
	output logic [mips_pkg::DATA_W-1:0]     rt_data
);

	import mips_pkg::*;

	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	logic [DATA_W-1:0] regs [NUM_REGS];

	// Register zero never takes a write
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (reg_write && (write_register != '0))
		begin
			regs[write_register] <= write_data;
		end
	end

	////////////////////
	// Read ports
	////////////////////
	// Writeback data in flight wins over the stored value
	function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
		logic [DATA_W-1:0] value;
		if (addr == '0)
			value = '0;
		else if (reg_write && (write_register == addr))
			value = write_data;
		else
			value = regs[addr];
		return value;
	endfunction

	always_comb
	begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`default_nettype none

module decode_stage (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            instr_valid,
	input  logic [mips_pkg::DATA_W-1:0]     instr,
	input  logic [mips_pkg::DATA_W-1:0]     pc_next,
	input  logic                            reg_write,
	input  logic [mips_pkg::REG_ADDR_W-1:0] write_register,
	input  logic [mips_pkg::DATA_W-1:0]     write_data,
	input  logic                            flush,

	output logic                            out_valid,
	output logic [mips_pkg::DATA_W-1:0]     out_pc_next,
	output logic [mips_pkg::DATA_W-1:0]     read_data_1,
	output logic [mips_pkg::DATA_W-1:0]     read_data_2,
	output logic [mips_pkg::DATA_W-1:0]     sign_imm,
	output logic [mips_pkg::REG_ADDR_W-1:0] out_rs,
	output logic [mips_pkg::REG_ADDR_W-1:0] out_rt,
	output logic [mips_pkg::REG_ADDR_W-1:0] out_rd,
	output logic [mips_pkg::REG_ADDR_W-1:0] out_shamt,
	output logic [mips_pkg::EXEC_W-1:0]     exec_ctrl,
	output logic [mips_pkg::MEM_W-1:0]      mem_ctrl,
	output logic [mips_pkg::WB_W-1:0]       wb_ctrl,

	output logic [mips_pkg::DATA_W-1:0]     jump_target,
	output logic [mips_pkg::DATA_W-1:0]     jump_reg_target,
	output logic                            jump,
	output logic                            jump_register,
	output logic                            stall
);

	import mips_pkg::*;

	////////////////////
	// Field extraction
	////////////////////
	logic [OPCODE_W-1:0]   opcode;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;
	logic [REG_ADDR_W-1:0] shamt;
	logic [FUNCT_W-1:0]    funct;
	logic [15:0]           imm;
	logic [25:0]           jidx;

	assign opcode = instr[OPCODE_MSB:OPCODE_LSB];
	assign rs     = instr[RS_MSB:RS_LSB];
	assign rt     = instr[RT_MSB:RT_LSB];
	assign rd     = instr[RD_MSB:RD_LSB];
	assign shamt  = instr[SHAMT_MSB:SHAMT_LSB];
	assign funct  = instr[FUNCT_MSB:FUNCT_LSB];
	assign imm    = instr[IMM_MSB:IMM_LSB];
	assign jidx   = instr[JIDX_MSB:JIDX_LSB];

	logic [DATA_W-1:0] imm_ext;

	assign imm_ext = {{(DATA_W - 16){imm[15]}}, imm};

	// Decoded control for the instruction now in decode
	logic [EXEC_W-1:0] dec_exec;
	logic [MEM_W-1:0]  dec_mem;
	logic [WB_W-1:0]   dec_wb;

	main_control u_main_control (
		.opcode    (opcode),
		.funct     (funct),
		.exec_ctrl (dec_exec),
		.mem_ctrl  (dec_mem),
		.wb_ctrl   (dec_wb)
	);

	logic [DATA_W-1:0] rs_val;
	logic [DATA_W-1:0] rt_val;

	register_file u_register_file (
		.clk            (clk),
		.reset          (reset),
		.rs_addr        (rs),
		.rt_addr        (rt),
		.reg_write      (reg_write),
		.write_register (write_register),
		.write_data     (write_data),
		.rs_data        (rs_val),
		.rt_data        (rt_val)
	);

	////////////////////
	// Load-use hazard
	////////////////////
	// The held ID/EX entry is a load whose target is read here
	logic hazard;

	assign hazard = instr_valid && out_valid && mem_ctrl[MEM_READ]
		&& (out_rt != '0) && ((out_rt == rs) || (out_rt == rt));

	// Combinational outputs, all forced low by flush
	assign stall           = flush ? 1'b0 : hazard;
	assign jump            = flush ? 1'b0 : dec_exec[EX_JUMP];
	assign jump_register   = flush ? 1'b0 : dec_exec[EX_JUMP_REG];
	assign jump_target     = flush ? '0 : {pc_next[DATA_W-1 -: 4], jidx, 2'b00};
	assign jump_reg_target = flush ? '0 : rs_val;

	////////////////////
	// ID/EX register
	////////////////////
	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			out_valid   <= 1'b0;
			out_pc_next <= '0;
			read_data_1 <= '0;
			read_data_2 <= '0;
			sign_imm    <= '0;
			out_rs      <= '0;
			out_rt      <= '0;
			out_rd      <= '0;
			out_shamt   <= '0;
			exec_ctrl   <= '0;
			mem_ctrl    <= '0;
			wb_ctrl     <= '0;
		end
		else if (instr_valid)
		begin
			out_valid   <= 1'b1;
			out_pc_next <= pc_next;
			read_data_1 <= rs_val;
			read_data_2 <= rt_val;
			sign_imm    <= imm_ext;
			out_rs      <= rs;
			out_rt      <= rt;
			out_rd      <= rd;
			out_shamt   <= shamt;
			// A stalled instruction becomes a bubble and is re-presented
			if (hazard)
			begin
				exec_ctrl <= '0;
				mem_ctrl  <= '0;
				wb_ctrl   <= '0;
			end
			else
			begin
				exec_ctrl <= dec_exec;
				mem_ctrl  <= dec_mem;
				wb_ctrl   <= dec_wb;
			end
		end
		else
		begin
			// No instruction this cycle, payload is left as it was
			out_valid <= 1'b0;
			exec_ctrl <= '0;
			mem_ctrl  <= '0;
			wb_ctrl   <= '0;
		end
	end

endmodule

`default_nettype wire

//--- verif/decode_properties.sv
`default_nettype none

module decode_properties (
	input logic                          clk,
	input logic                          reset,
	input logic                          flush,
	input logic                          stall,
	input logic                          out_valid,
	input logic [mips_pkg::EXEC_W-1:0]   exec_ctrl,
	input logic [mips_pkg::MEM_W-1:0]    mem_ctrl,
	input logic [mips_pkg::WB_W-1:0]     wb_ctrl
);
	timeunit 1ns;
	timeprecision 100ps;

	// Flush overrides any hazard in its cycle
	stall_not_with_flush: assert property (@(posedge clk) disable iff (reset)
		flush |-> !stall)
		else $error("stall high while flush is high");

	flush_clears_valid: assert property (@(posedge clk) disable iff (reset)
		flush |=> !out_valid)
		else $error("out_valid high after flush");

	// A stalled instruction leaves a bubble in ID/EX
	stall_makes_bubble: assert property (@(posedge clk) disable iff (reset)
		stall |=> (exec_ctrl == '0) && (mem_ctrl == '0) && (wb_ctrl == '0))
		else $error("control words nonzero after stall");

endmodule

bind decode_stage decode_properties u_properties (.clk(clk), .reset(reset), .flush(flush),
	.stall(stall), .out_valid(out_valid), .exec_ctrl(exec_ctrl), .mem_ctrl(mem_ctrl),
	.wb_ctrl(wb_ctrl));

`default_nettype wire

//--- verif/decode_tb.sv
`default_nettype none

module decode_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import mips_pkg::*;

	localparam int MAX_WAIT = 20;

	logic clk;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	logic [31:0] pc_next;
	logic reg_write;
	logic [4:0] write_register;
	logic [31:0] write_data;
	logic flush;
	logic out_valid;
	logic [31:0] out_pc_next;
	logic [31:0] read_data_1;
	logic [31:0] read_data_2;
	logic [31:0] sign_imm;
	logic [4:0] out_rs;
	logic [4:0] out_rt;
	logic [4:0] out_rd;
	logic [4:0] out_shamt;
	logic [EXEC_W-1:0] exec_ctrl;
	logic [MEM_W-1:0] mem_ctrl;
	logic [WB_W-1:0] wb_ctrl;
	logic [31:0] jump_target;
	logic [31:0] jump_reg_target;
	logic jump;
	logic jump_register;
	logic stall;

	decode_stage i_dut (.*);

	integer seed = 32'hecd811c4;
	int errors = 0;
	int checks = 0;

	////////////////////
	// Reference model state
	////////////////////
	logic [31:0] shadow [32];
	logic e_valid;
	logic [31:0] e_pc, e_rd1, e_rd2, e_imm;
	logic [4:0] e_rs, e_rt, e_rd, e_shamt;
	logic [14:0] e_ctrl;

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [14:0] ctrl_word(input logic rdst, asrc, input logic [3:0] op,
		input logic sh, j, jr, beq, bne, mr, mw, rw, m2r);
		return {rdst, asrc, op, sh, j, jr, beq, bne, mr, mw, rw, m2r};
	endfunction

	// Expected execute, memory and writeback words packed high to low
	function automatic logic [14:0] ref_ctrl(input logic [5:0] op, input logic [5:0] fn);
		logic [14:0] w;
		w = '0;
		case (op)
			OP_RTYPE:
				case (fn)
					FN_ADD: w = ctrl_word(1, 0, ALU_ADD, 0, 0, 0, 0, 0, 0, 0, 1, 0);
					FN_SUB: w = ctrl_word(1, 0, ALU_SUB, 0, 0, 0, 0, 0, 0, 0, 1, 0);
					FN_AND: w = ctrl_word(1, 0, ALU_AND, 0, 0, 0, 0, 0, 0, 0, 1, 0);
					FN_OR:  w = ctrl_word(1, 0, ALU_OR, 0, 0, 0, 0, 0, 0, 0, 1, 0);
					FN_SLT: w = ctrl_word(1, 0, ALU_SLT, 0, 0, 0, 0, 0, 0, 0, 1, 0);
					FN_SLL: w = ctrl_word(1, 0, ALU_SLL, 1, 0, 0, 0, 0, 0, 0, 1, 0);
					FN_SRL: w = ctrl_word(1, 0, ALU_SRL, 1, 0, 0, 0, 0, 0, 0, 1, 0);
					FN_JR:  w = ctrl_word(0, 0, ALU_NOP, 0, 0, 1, 0, 0, 0, 0, 0, 0);
					default: w = '0;
				endcase
			OP_ADDI: w = ctrl_word(0, 1, ALU_ADD, 0, 0, 0, 0, 0, 0, 0, 1, 0);
			OP_ANDI: w = ctrl_word(0, 1, ALU_AND, 0, 0, 0, 0, 0, 0, 0, 1, 0);
			OP_ORI:  w = ctrl_word(0, 1, ALU_OR, 0, 0, 0, 0, 0, 0, 0, 1, 0);
			OP_LW:   w = ctrl_word(0, 1, ALU_ADD, 0, 0, 0, 0, 0, 1, 0, 1, 1);
			OP_SW:   w = ctrl_word(0, 1, ALU_ADD, 0, 0, 0, 0, 0, 0, 1, 0, 0);
			OP_BEQ:  w = ctrl_word(0, 0, ALU_SUB, 0, 0, 0, 1, 0, 0, 0, 0, 0);
			OP_BNE:  w = ctrl_word(0, 0, ALU_SUB, 0, 0, 0, 0, 1, 0, 0, 0, 0);
			OP_J:    w = ctrl_word(0, 0, ALU_NOP, 0, 1, 0, 0, 0, 0, 0, 0, 0);
			default: w = '0;
		endcase
		return w;
	endfunction

	// Shadow read with same-cycle writeback bypass
	function automatic logic [31:0] model_read(input logic [4:0] a);
		if (a == 5'd0)
			return 32'd0;
		if (reg_write && write_register == a)
			return write_data;
		return shadow[a];
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("FAIL %s expected %h got %h", name, exp, act);
		end
	endtask

	////////////////////
	// Cycle checker
	////////////////////
	task automatic check_cycle();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [14:0] c;
		logic hz;
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				shadow[i] = '0;
			{e_valid, e_pc, e_rd1, e_rd2, e_imm, e_rs, e_rt, e_rd, e_shamt, e_ctrl} = '0;
			return;
		end
		check_val("out_valid", 32'(e_valid), 32'(out_valid));
		check_val("out_pc_next", e_pc, out_pc_next);
		check_val("read_data_1", e_rd1, read_data_1);
		check_val("read_data_2", e_rd2, read_data_2);
		check_val("sign_imm", e_imm, sign_imm);
		check_val("out_rs", 32'(e_rs), 32'(out_rs));
		check_val("out_rt", 32'(e_rt), 32'(out_rt));
		check_val("out_rd", 32'(e_rd), 32'(out_rd));
		check_val("out_shamt", 32'(e_shamt), 32'(out_shamt));
		check_val("exec_ctrl", 32'(e_ctrl[14:4]), 32'(exec_ctrl));
		check_val("mem_ctrl", 32'(e_ctrl[3:2]), 32'(mem_ctrl));
		check_val("wb_ctrl", 32'(e_ctrl[1:0]), 32'(wb_ctrl));

		rs = instr[25:21];
		rt = instr[20:16];
		c = ref_ctrl(instr[31:26], instr[5:0]);
		hz = instr_valid && e_valid && e_ctrl[3] && (e_rt != 0) && (e_rt == rs || e_rt == rt);

		check_val("stall", 32'(flush ? 1'b0 : hz), 32'(stall));
		check_val("jump", 32'(flush ? 1'b0 : c[7]), 32'(jump));
		check_val("jump_register", 32'(flush ? 1'b0 : c[6]), 32'(jump_register));
		check_val("jump_target", flush ? 32'd0 : {pc_next[31:28], instr[25:0], 2'b00},
			jump_target);
		check_val("jump_reg_target", flush ? 32'd0 : model_read(rs), jump_reg_target);

		// Next ID/EX contents
		if (flush)
			{e_valid, e_pc, e_rd1, e_rd2, e_imm, e_rs, e_rt, e_rd, e_shamt, e_ctrl} = '0;
		else if (instr_valid)
		begin
			e_valid = 1'b1;
			e_pc = pc_next;
			e_rd1 = model_read(rs);
			e_rd2 = model_read(rt);
			e_imm = {{16{instr[15]}}, instr[15:0]};
			e_rs = rs;
			e_rt = rt;
			e_rd = instr[15:11];
			e_shamt = instr[10:6];
			e_ctrl = hz ? 15'd0 : c;
		end
		else
		begin
			e_valid = 1'b0;
			e_ctrl = '0;
		end
		if (reg_write && write_register != 0)
			shadow[write_register] = write_data;
	endtask

	always @(negedge clk)
		check_cycle();

	////////////////////
	// Stimulus helpers
	////////////////////
	task automatic step(input logic v, input logic [31:0] ins, input logic [31:0] pc,
		input logic we, input logic [4:0] wr, input logic [31:0] wd, input logic fl);
		@(posedge clk);
		instr_valid <= v;
		instr <= ins;
		pc_next <= pc;
		reg_write <= we;
		write_register <= wr;
		write_data <= wd;
		flush <= fl;
	endtask

	task automatic rand_instr(output logic [31:0] ins);
		int pick;
		logic [31:0] r;
		logic [5:0] bad_ops [4];
		logic [5:0] fns [8];
		bad_ops = '{6'h01, 6'h03, 6'h10, 6'h3f};
		fns = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL, FN_SRL, FN_JR};
		pick = $unsigned($random(seed)) % 18;
		r = $random(seed);
		case (pick)
			0, 1, 2, 3, 4, 5, 6, 7: ins = {OP_RTYPE, r[25:6], fns[pick]};
			8:  ins = {OP_ADDI, r[25:0]};
			9:  ins = {OP_ANDI, r[25:0]};
			10: ins = {OP_ORI, r[25:0]};
			11: ins = {OP_LW, r[25:0]};
			12: ins = {OP_SW, r[25:0]};
			13: ins = {OP_BEQ, r[25:0]};
			14: ins = {OP_BNE, r[25:0]};
			15: ins = {OP_J, r[25:0]};
			16: ins = {bad_ops[r[31:30]], r[25:0]};
			default: ins = {OP_RTYPE, r[25:6], 6'h3f};
		endcase
	endtask

	task automatic wait_out_valid();
		for (int i = 0; i < MAX_WAIT; i++)
		begin
			@(negedge clk);
			if (out_valid)
				return;
		end
		errors++;
		$display("Timed out waiting for out_valid");
	endtask

	task automatic report_test(input string name, input int start);
		$display("Test %s done with %0d errors", name, errors - start);
	endtask

	task automatic random_cycles(input int n, input int flush_pct);
		logic [31:0] ins;
		logic [31:0] r;
		for (int i = 0; i < n; i++)
		begin
			rand_instr(ins);
			r = $random(seed);
			step(r[1:0] != 2'b00, ins, $random(seed), r[2], r[7:3], $random(seed),
				(r[15:8] % 100) < flush_pct);
		end
	endtask

	////////////////////
	// Tests
	////////////////////
	initial
	begin
		int start;
		logic [31:0] r;
		reset = 1'b1;
		{instr_valid, instr, pc_next, reg_write, write_register, write_data, flush} = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		start = errors;
		random_cycles(200, 0);
		report_test("random decode and control", start);

		start = errors;
		for (int i = 1; i < 32; i++)
			step(0, 0, 0, 1, i[4:0], $random(seed), 0);
		for (int i = 0; i < 60; i++)
		begin
			r = $random(seed);
			step(1, {OP_RTYPE, r[9:5], r[14:10], 10'd0, FN_ADD}, r, r[15], r[9:5],
				$random(seed), 0);
		end
		report_test("register file", start);

		start = errors;
		step(1, {OP_LW, 5'd2, 5'd5, 16'h0010}, 32'h100, 0, 0, 0, 0);
		step(1, {OP_RTYPE, 5'd5, 5'd3, 5'd7, 5'd0, FN_ADD}, 32'h104, 0, 0, 0, 0);
		@(negedge clk);
		check_val("stall", 1, 32'(stall));
		step(1, {OP_RTYPE, 5'd5, 5'd3, 5'd7, 5'd0, FN_ADD}, 32'h104, 0, 0, 0, 0);
		@(negedge clk);
		check_val("stall", 0, 32'(stall));
		check_val("exec_ctrl", 0, 32'(exec_ctrl));
		step(1, {OP_LW, 5'd2, 5'd0, 16'h0020}, 32'h108, 0, 0, 0, 0);
		step(1, {OP_RTYPE, 5'd0, 5'd0, 5'd9, 5'd0, FN_OR}, 32'h10c, 0, 0, 0, 0);
		@(negedge clk);
		check_val("stall", 0, 32'(stall));
		step(0, 0, 0, 0, 0, 0, 0);
		wait_out_valid();
		report_test("load-use stall", start);

		start = errors;
		step(1, {OP_ADDI, 5'd1, 5'd2, 16'h8000}, 32'h200, 0, 0, 0, 0);
		step(0, 0, 0, 0, 0, 0, 0);
		wait_out_valid();
		// Load into r5, then a flushed jump whose rs is r5 and is written back
		step(1, {OP_LW, 5'd2, 5'd5, 16'h0004}, 32'h204, 0, 0, 0, 0);
		step(1, {OP_J, 5'd5, 21'h1fffff}, 32'hf000_0000, 1, 5'd5, 32'hdead_beef, 1);
		@(negedge clk);
		check_val("stall", 0, 32'(stall));
		check_val("jump", 0, 32'(jump));
		check_val("jump_target", 0, jump_target);
		check_val("jump_reg_target", 0, jump_reg_target);
		step(1, {OP_RTYPE, 5'd5, 15'd0, FN_JR}, 32'h208, 0, 0, 0, 1);
		@(negedge clk);
		check_val("jump_register", 0, 32'(jump_register));
		step(1, {OP_LW, 5'd3, 5'd4, 16'h0008}, 32'h20c, 0, 0, 0, 1);
		step(0, 0, 0, 0, 0, 0, 0);
		@(negedge clk);
		check_val("out_valid", 0, 32'(out_valid));
		check_val("exec_ctrl", 0, 32'(exec_ctrl));
		check_val("mem_ctrl", 0, 32'(mem_ctrl));
		check_val("wb_ctrl", 0, 32'(wb_ctrl));
		random_cycles(120, 25);
		report_test("flush", start);

		step(0, 0, 0, 0, 0, 0, 0);
		@(negedge clk);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hw/mips_pkg.sv
hw/main_control.sv
hw/register_file.sv
hw/decode_stage.sv
verif/decode_properties.sv
verif/decode_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_tb -f build.f -o decode_sim

./obj_dir/decode_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
exit 0
